/* include/display_settings.svh */
`ifndef DISPLAY_SETTINGS_SVH
`define DISPLAY_SETTINGS_SVH

// Panel geometry
`define PIXEL_WIDTH 64
`define PIXEL_HEIGHT 32
`define BYTES_PER_PIXEL 3

// Host command opcodes
`define OPC_LOAD_PIXEL 8'h01
`define OPC_FILL_FRAME 8'h02
`define OPC_SWAP_BANKS 8'h03

`endif

/* src/display_pkg.sv */
`include "display_settings.svh"

package display_pkg;

    typedef logic [$clog2(`PIXEL_HEIGHT)-1:0] row_t;         // Low bits of the row byte
    typedef logic [$clog2(`PIXEL_WIDTH)-1:0] column_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_sel_t; // Colour byte within a pixel

    // One byte of the frame buffer
    typedef struct packed {
        row_t       row;
        column_t    column;
        pixel_sel_t pixel_sel;
    } pixel_addr_t;

endpackage

/* src/command_pkg.sv */
`include "display_settings.svh"

package command_pkg;

    typedef enum logic [7:0] {
        OP_LOAD_PIXEL = `OPC_LOAD_PIXEL,
        OP_FILL_FRAME = `OPC_FILL_FRAME,
        OP_SWAP_BANKS = `OPC_SWAP_BANKS
    } opcode_t;

    // Write request from a handler to the frame buffer
    typedef struct packed {
        display_pkg::pixel_addr_t addr;
        logic [7:0]               data;
        logic                     write_enable;
        logic                     access_toggle; // Flips once per byte to write
    } ram_write_req_t;

endpackage

/* src/command_dispatch.sv */
`timescale 1ns/1ns

module command_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_data,
    input  logic       byte_strobe,
    input  logic       load_done,
    input  logic       fill_done,
    output logic [7:0] arg_data,
    output logic       load_enable,
    output logic       fill_enable,
    output logic       swap_pulse,
    output logic       busy
);
    typedef enum logic {
        ST_IDLE,
        ST_ROUTE
    } dispatch_state_t;

    dispatch_state_t      state;
    command_pkg::opcode_t target;  // Handler that owns the argument bytes
    command_pkg::opcode_t opcode;

    assign opcode   = command_pkg::opcode_t'(byte_data);
    assign arg_data = byte_data;
    assign busy     = (state == ST_ROUTE);

    // Argument strobes go straight through to the selected handler
    assign load_enable = byte_strobe && busy && (target == command_pkg::OP_LOAD_PIXEL);
    assign fill_enable = byte_strobe && busy && (target == command_pkg::OP_FILL_FRAME);
    assign swap_pulse  = byte_strobe && !busy && (opcode == command_pkg::OP_SWAP_BANKS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= ST_IDLE;
            target <= command_pkg::OP_LOAD_PIXEL;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (byte_strobe && (opcode == command_pkg::OP_LOAD_PIXEL ||
                                        opcode == command_pkg::OP_FILL_FRAME)) begin
                        target <= opcode;
                        state  <= ST_ROUTE;
                    end  // Swap needs no routing, unknown bytes are ignored
                end
                ST_ROUTE: begin
                    if ((target == command_pkg::OP_LOAD_PIXEL && load_done) ||
                        (target == command_pkg::OP_FILL_FRAME && fill_done)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // A done pulse only comes from the handler currently routed to
    a_done_from_target: assert property (@(posedge clk) disable iff (reset)
        (load_done || fill_done) |->
            busy && ((load_done && target == command_pkg::OP_LOAD_PIXEL) ||
                     (fill_done && target == command_pkg::OP_FILL_FRAME)));

endmodule

/* src/cmd_load_pixel.sv */
`timescale 1ns/1ns
`include "display_settings.svh"

module cmd_load_pixel (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  logic [7:0]                  data_in,
    output command_pkg::ram_write_req_t load_req,
    output logic                        done
);
    typedef enum logic [2:0] {
        S_ROW,
        S_COLUMN,
        S_PRIME,
        S_COLOUR,
        S_DONE
    } load_state_t;

    load_state_t             state;
    display_pkg::row_t       row;
    logic [7:0]              column_byte;  // One byte covers the full width
    display_pkg::pixel_sel_t sel_count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= S_ROW;
            row         <= '0;
            column_byte <= 8'd0;
            sel_count   <= '0;
            load_req    <= '0;
            done        <= 1'b0;
        end else begin
            case (state)
                S_ROW: begin
                    if (enable) begin
                        row   <= display_pkg::row_t'(data_in);
                        state <= S_COLUMN;
                    end
                end
                S_COLUMN: begin
                    if (enable) begin
                        column_byte <= data_in;
                        state       <= S_PRIME;
                    end
                end
                S_PRIME: begin
                    // Byte value is not used, it only arms the write path
                    if (enable) begin
                        load_req.write_enable <= 1'b1;
                        sel_count <= display_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1);
                        state     <= S_COLOUR;
                    end
                end
                S_COLOUR: begin
                    if (enable) begin
                        load_req.addr.row       <= row;
                        load_req.addr.column    <= display_pkg::column_t'(column_byte);
                        load_req.addr.pixel_sel <= sel_count;
                        load_req.data           <= data_in;
                        load_req.access_toggle  <= !load_req.access_toggle;
                        if (sel_count == '0) begin
                            done  <= 1'b1;
                            state <= S_DONE;
                        end else begin
                            sel_count <= sel_count - 1'b1;
                        end
                    end
                end
                S_DONE: begin
                    // Buffer takes the last byte on this edge
                    done                  <= 1'b0;
                    load_req.write_enable <= 1'b0;
                    state                 <= S_ROW;
                end
                default: state <= S_ROW;
            endcase
        end
    end

    // Row byte has no bits set above the last row
    a_row_in_range: assert property (@(posedge clk) disable iff (reset)
        (state == S_ROW && enable) |-> (data_in <= `PIXEL_HEIGHT - 1));

endmodule

/* src/cmd_fill_frame.sv */
`timescale 1ns/1ns
`include "display_settings.svh"

module cmd_fill_frame (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  logic [7:0]                  data_in,
    output command_pkg::ram_write_req_t fill_req,
    output logic                        done
);
    typedef enum logic [1:0] {
        F_COLLECT,
        F_SWEEP,
        F_DONE
    } fill_state_t;

    fill_state_t              state;
    logic [7:0]               colour [`BYTES_PER_PIXEL];
    display_pkg::pixel_sel_t  collect_sel;  // First byte lands at the top index
    display_pkg::pixel_addr_t walk;
    logic                     walk_last;

    assign walk_last = (walk.row == display_pkg::row_t'(`PIXEL_HEIGHT - 1)) &&
                       (walk.column == display_pkg::column_t'(`PIXEL_WIDTH - 1)) &&
                       (walk.pixel_sel == display_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1));

    always_ff @(posedge clk) begin
        if (state == F_COLLECT && enable) begin
            colour[collect_sel] <= data_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= F_COLLECT;
            collect_sel <= display_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1);
            walk        <= '0;
            fill_req    <= '0;
            done        <= 1'b0;
        end else begin
            case (state)
                F_COLLECT: begin
                    if (enable) begin
                        if (collect_sel == '0) begin
                            fill_req.write_enable <= 1'b1;
                            walk  <= '0;
                            state <= F_SWEEP;
                        end else begin
                            collect_sel <= collect_sel - 1'b1;
                        end
                    end
                end
                // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                // One byte per cycle, row then column then colour byte
                // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
                F_SWEEP: begin
                    fill_req.addr          <= walk;
                    fill_req.data          <= colour[walk.pixel_sel];
                    fill_req.access_toggle <= !fill_req.access_toggle;
                    if (walk_last) begin
                        done  <= 1'b1;
                        state <= F_DONE;
                    end else if (walk.pixel_sel ==
                                 display_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1)) begin
                        walk.pixel_sel <= '0;
                        if (walk.column == display_pkg::column_t'(`PIXEL_WIDTH - 1)) begin
                            walk.column <= '0;
                            walk.row    <= walk.row + 1'b1;
                        end else begin
                            walk.column <= walk.column + 1'b1;
                        end
                    end else begin
                        walk.pixel_sel <= walk.pixel_sel + 1'b1;
                    end
                end
                F_DONE: begin
                    done                  <= 1'b0;
                    fill_req.write_enable <= 1'b0;
                    collect_sel <= display_pkg::pixel_sel_t'(`BYTES_PER_PIXEL - 1);
                    state       <= F_COLLECT;
                end
                default: state <= F_COLLECT;
            endcase
        end
    end

endmodule

/* src/bank_select_regs.sv */
`timescale 1ns/1ns

module bank_select_regs (
    input  logic clk,
    input  logic reset,
    input  logic swap_pulse,
    output logic front_bank
);
    // Bank 0 is shown after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            front_bank <= 1'b0;
        end else if (swap_pulse) begin
            front_bank <= !front_bank;
        end
    end

    // A held pulse would flip the banks back
    a_swap_single: assert property (@(posedge clk) disable iff (reset)
        swap_pulse |=> !swap_pulse);

endmodule

/* src/frame_buffer.sv */
`timescale 1ns/1ns
`include "display_settings.svh"

module frame_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  command_pkg::ram_write_req_t load_req,
    input  command_pkg::ram_write_req_t fill_req,
    input  logic                        front_bank,
    input  display_pkg::pixel_addr_t    read_addr,
    output logic [7:0]                  read_data
);
    localparam int BANK_BYTES = `PIXEL_WIDTH * `PIXEL_HEIGHT * `BYTES_PER_PIXEL;

    logic [7:0] mem [2][BANK_BYTES];
    logic       load_toggle_q;
    logic       fill_toggle_q;
    logic       load_write;
    logic       fill_write;

    function automatic int byte_offset(display_pkg::pixel_addr_t addr);
        return (addr.row * `PIXEL_WIDTH + addr.column) * `BYTES_PER_PIXEL + addr.pixel_sel;
    endfunction

    // A changed toggle marks a new byte
    assign load_write = load_req.write_enable && (load_req.access_toggle != load_toggle_q);
    assign fill_write = fill_req.write_enable && (fill_req.access_toggle != fill_toggle_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_toggle_q <= 1'b0;
            fill_toggle_q <= 1'b0;
        end else begin
            load_toggle_q <= load_req.access_toggle;
            fill_toggle_q <= fill_req.access_toggle;
        end
    end

    always_ff @(posedge clk) begin
        if (load_write) begin
            mem[!front_bank][byte_offset(load_req.addr)] <= load_req.data;  // Back bank only
        end else if (fill_write) begin
            mem[!front_bank][byte_offset(fill_req.addr)] <= fill_req.data;
        end
        read_data <= mem[front_bank][byte_offset(read_addr)];
    end

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        !((load_req.access_toggle != load_toggle_q) &&
          (fill_req.access_toggle != fill_toggle_q)));

endmodule

/* src/display_cmd_top.sv */
`timescale 1ns/1ns

module display_cmd_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               byte_data,
    input  logic                     byte_strobe,
    output logic                     busy,
    input  display_pkg::pixel_addr_t read_addr,
    output logic [7:0]               read_data
);
    logic [7:0]                  arg_data;
    logic                        load_enable;
    logic                        fill_enable;
    logic                        load_done;
    logic                        fill_done;
    logic                        swap_pulse;
    logic                        front_bank;
    command_pkg::ram_write_req_t load_req;
    command_pkg::ram_write_req_t fill_req;

    command_dispatch dispatch0 (
        .clk, .reset, .byte_data, .byte_strobe, .load_done, .fill_done,
        .arg_data, .load_enable, .fill_enable, .swap_pulse, .busy
    );

    cmd_load_pixel load0 (
        .clk, .reset, .enable(load_enable), .data_in(arg_data),
        .load_req, .done(load_done)
    );

    cmd_fill_frame fill0 (
        .clk, .reset, .enable(fill_enable), .data_in(arg_data),
        .fill_req, .done(fill_done)
    );

    bank_select_regs banks0 (.clk, .reset, .swap_pulse, .front_bank);

    frame_buffer fb0 (
        .clk, .reset, .load_req, .fill_req, .front_bank, .read_addr, .read_data
    );

endmodule

/* testbench/tb_display_cmd.sv */
`timescale 1ns/1ns

module tb_display_cmd;

    logic                     clk = 1'b0;
    logic                     reset;
    logic [7:0]               byte_data;
    logic                     byte_strobe;
    logic                     busy;
    display_pkg::pixel_addr_t read_addr;
    logic [7:0]               read_data;

    integer           seed = 32'hd46e;
    integer           fd;
    integer           n;
    int               errors = 0;
    int               checks = 0;
    int               tests = 0;
    int               test_start_errors = 0;
    logic             timed_out = 1'b0;
    logic [63:0]      kind;      // Trace entry letter
    logic [8*160-1:0] line;
    int               test;
    int               count;
    int               i;
    int               busy_exp;
    logic [7:0]       value;
    logic [7:0]       row;
    logic [7:0]       column;
    logic [7:0]       b2;
    logic [7:0]       b1;
    logic [7:0]       b0;

    display_cmd_top dut0 (
        .clk, .reset, .byte_data, .byte_strobe, .busy, .read_addr, .read_data
    );

    always #5 clk = !clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_byte(input logic [7:0] data);
        int gap;
        byte_data   = data;
        byte_strobe = 1'b1;
        @(negedge clk);
        byte_strobe = 1'b0;
        gap = $unsigned($random(seed)) % 4;  // 0 to 3 idle cycles
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_idle(input int test_num);
        int cycles;
        cycles = 0;
        while (busy && cycles < 8000) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("Wait for idle timed out after %0d cycles in test %0d", cycles, test_num);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_busy(input logic expected);
        checks++;
        assert (busy == expected) else begin
            $display("CHECK FAILED at %0t: busy is %0b, expected %0b", $time, busy, expected);
            errors++;
        end
    endtask

    task automatic check_trace_fields(input int got, input int want);
        if (got != want) begin
            $display("Trace entry %0s in test %0d is missing values", kind, test);
            errors++;
        end
    endtask

    // Reads the three colour bytes of one pixel, byte 2 first
    task automatic check_pixel(input logic [7:0] r, input logic [7:0] c,
                               input logic [23:0] expected);
        int         sel;
        logic [7:0] want;
        for (sel = 2; sel >= 0; sel--) begin
            want                = expected[8*sel +: 8];
            read_addr.row       = display_pkg::row_t'(r);
            read_addr.column    = display_pkg::column_t'(c);
            read_addr.pixel_sel = display_pkg::pixel_sel_t'(sel);
            @(negedge clk);  // Registered read port
            checks++;
            assert (read_data == want) else begin
                $display("CHECK FAILED at %0t: row %0d column %0d byte %0d expected %02h got %02h",
                         $time, r, c, sel, want, read_data);
                errors++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Trace player
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset       = 1'b1;
        byte_data   = 8'h00;
        byte_strobe = 1'b0;
        read_addr   = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("testbench/display_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file testbench/display_trace.txt");
            errors++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    n = $fgets(line, fd);
                end else if (kind == "S") begin
                    n = $fscanf(fd, "%d %d", test, count);
                    check_trace_fields(n, 2);
                    for (i = 0; i < count; i++) begin
                        n = $fscanf(fd, "%h", value);
                        check_trace_fields(n, 1);
                        send_byte(value);
                    end
                end else if (kind == "W") begin
                    n = $fscanf(fd, "%d", test);
                    check_trace_fields(n, 1);
                    wait_idle(test);
                end else if (kind == "B") begin
                    n = $fscanf(fd, "%d %d", test, busy_exp);
                    check_trace_fields(n, 2);
                    check_busy(busy_exp[0]);
                end else if (kind == "R") begin
                    n = $fscanf(fd, "%d %h %h %h %h %h", test, row, column, b2, b1, b0);
                    check_trace_fields(n, 6);
                    check_pixel(row, column, {b2, b1, b0});
                end else if (kind == "E") begin
                    n = $fscanf(fd, "%d", test);
                    check_trace_fields(n, 1);
                    tests++;
                    if (errors == test_start_errors) begin
                        $display("Test %0d passed", test);
                    end else begin
                        $display("Test %0d failed with %0d errors", test,
                                 errors - test_start_errors);
                    end
                    test_start_errors = errors;
                end else begin
                    $display("Unknown entry %0s in the trace file", kind);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
src/display_pkg.sv
src/command_pkg.sv
src/command_dispatch.sv
src/cmd_load_pixel.sv
src/cmd_fill_frame.sv
src/bank_select_regs.sv
src/frame_buffer.sv
src/display_cmd_top.sv
testbench/tb_display_cmd.sv

/* testbench/display_trace.txt */
# Columns: kind test values. S test count bytes... sends bytes (hex), B test busy, W test waits idle
# R test row column byte2 byte1 byte0 (hex) reads one pixel, E test ends the test
B 1 0
S 1 4 02 11 22 33
W 1
S 1 1 03
R 1 00 00 11 22 33
R 1 1f 3f 11 22 33
R 1 00 3f 11 22 33
E 1
S 2 4 02 44 55 66
W 2
S 2 1 03
S 2 7 01 05 28 00 a1 b2 c3
W 2
S 2 1 03
R 2 05 28 a1 b2 c3
R 2 05 27 11 22 33
R 2 05 29 11 22 33
E 2
S 3 7 01 05 28 00 d4 e5 f6
W 3
R 3 05 28 a1 b2 c3
E 3
S 4 4 02 77 88 99
B 4 1
S 4 3 01 0a 0b
W 4
S 4 7 01 0a 0b 00 12 34 56
W 4
S 4 1 03
R 4 0a 0b 12 34 56
R 4 0a 0c 77 88 99
E 4
S 5 1 7f
B 5 0
S 5 7 01 03 07 00 c1 c2 c3
W 5
S 5 1 03
R 5 03 07 c1 c2 c3
E 5
S 6 7 01 1f 3f 00 e1 e2 e3
W 6
S 6 1 03
R 6 1f 3f e1 e2 e3
E 6
